//--- ip_tx_pkg.sv
// ==========================================================================
// shared types and helpers for the IPv4 transmitter, 64-bit datapath only
// keep patterns must be contiguous from byte 0; IP options unsupported
// ==========================================================================
package ip_tx_pkg;

    localparam int bytes_per_word = 8;
    localparam int ip_hdr_bytes = 20;
    // version 4, IHL 5
    localparam logic [7:0] ip_version_ihl = 8'h45;

    typedef logic [63:0] data_t;
    typedef logic [7:0]  keep_t;
    typedef logic [47:0] mac_t;
    typedef logic [31:0] ipv4_t;
    typedef logic [15:0] len_t;
    typedef logic [15:0] csum_t;

    typedef struct packed {
        mac_t        dest_mac;
        mac_t        src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    typedef struct packed {
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        len_t        length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] frag_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        ipv4_t       src_ip;
        ipv4_t       dest_ip;
    } ip_hdr_t;

    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;
    } axis_word_t;

    // user marks a frame cut short
    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;
        logic  user;
    } axis_out_t;

    function automatic logic [3:0] keep_count(keep_t keep);
        logic [3:0] n;
        n = 4'd0;
        for (int i = 0; i < bytes_per_word; i++) begin
            if (keep[i]) begin
                n = 4'(i + 1);
            end
        end
        return n;
    endfunction

    function automatic keep_t count_keep(logic [3:0] n);
        keep_t keep;
        for (int i = 0; i < bytes_per_word; i++) begin
            keep[i] = (i < n);
        end
        return keep;
    endfunction

endpackage

//--- ip_hdr_checksum.sv
// ==========================================================================
// IPv4 header checksum, IHL 5 only
// load samples ip_hdr in the same cycle; csum is valid from the next cycle
// ==========================================================================
module ip_hdr_checksum
    import ip_tx_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    load,
    input  ip_hdr_t ip_hdr,
    output csum_t   csum
);

    logic [19:0] sum;
    logic [16:0] fold1;
    logic [15:0] fold2;

    // checksum field itself counts as zero
    always_comb begin
        sum = 20'({ip_version_ihl, ip_hdr.dscp, ip_hdr.ecn})
            + 20'(ip_hdr.length)
            + 20'(ip_hdr.identification)
            + 20'({ip_hdr.flags, ip_hdr.frag_offset})
            + 20'({ip_hdr.ttl, ip_hdr.protocol})
            + 20'(ip_hdr.src_ip[31:16])
            + 20'(ip_hdr.src_ip[15:0])
            + 20'(ip_hdr.dest_ip[31:16])
            + 20'(ip_hdr.dest_ip[15:0]);
        fold1 = 17'(sum[15:0]) + 17'(sum[19:16]);
        fold2 = fold1[15:0] + 16'(fold1[16]);
    end

    always_ff @(posedge clk) begin
        if (load) begin
            csum <= ~fold2;
        end
    end

    // framer drops hdr_ready after each accept
    assert property (@(posedge clk) disable iff (rst) load |=> !load);

endmodule

//--- payload_realign.sv
// ==========================================================================
// shifts the payload by half a word so it follows the 20-byte IP header
// a last word with bytes in its upper half costs one extra output word
// ==========================================================================
module payload_realign
    import ip_tx_pkg::*;
#(
    parameter int data_bytes = 8
) (
    input  logic       clk,
    input  logic       rst,
    input  axis_word_t in_word,
    input  logic       in_valid,
    output logic       in_ready,
    output axis_word_t shift_word,
    output logic       shift_valid,
    input  logic       shift_take,
    input  logic       flush
);

    localparam int half_bytes = data_bytes / 2;
    localparam int half_bits = half_bytes * 8;

    // upper half of the previous input word
    logic [half_bits-1:0]  save_data;
    logic [half_bytes-1:0] save_keep;
    // held bytes still owed after the input frame ended
    logic extra;
    logic in_xfer;

    assign in_ready = shift_take && !extra;
    assign in_xfer = in_valid && in_ready;
    assign shift_valid = extra || in_valid;

    always_comb begin
        if (extra) begin
            shift_word.data = {{half_bits{1'b0}}, save_data};
            shift_word.keep = {{half_bytes{1'b0}}, save_keep};
            shift_word.last = 1'b1;
        end else begin
            shift_word.data = {in_word.data[half_bits-1:0], save_data};
            shift_word.keep = {in_word.keep[half_bytes-1:0], save_keep};
            shift_word.last = in_word.last
                && (in_word.keep[data_bytes-1:half_bytes] == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            extra <= 1'b0;
        end else if (flush) begin
            extra <= 1'b0;
        end else if (in_xfer) begin
            extra <= in_word.last && (in_word.keep[data_bytes-1:half_bytes] != '0);
        end
        if (in_xfer) begin
            save_data <= in_word.data[2*half_bits-1:half_bits];
            save_keep <= in_word.keep[data_bytes-1:half_bytes];
        end
    end

    assert property (@(posedge clk) disable iff (rst) shift_take |-> shift_valid);

endmodule

//--- ip_tx_framer.sv
// ==========================================================================
// frame FSM: three header words, then payload trimmed to the IP length
// words are offered only while frm_ready is high; extra input is dropped
// a new header is taken once the frame is done and eth_out has gone out
// ==========================================================================
module ip_tx_framer
    import ip_tx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       hdr_valid,
    output logic       hdr_ready,
    input  eth_hdr_t   eth_hdr,
    input  ip_hdr_t    ip_hdr,
    output logic       eth_valid,
    input  logic       eth_ready,
    output eth_hdr_t   eth_out,
    input  csum_t      csum,
    output logic       csum_load,
    input  axis_word_t shift_word,
    input  logic       shift_valid,
    output logic       shift_take,
    output logic       flush,
    output axis_out_t  frm_word,
    output logic       frm_valid,
    input  logic       frm_ready,
    input  logic       frm_ready_early,
    output logic       error_early_term
);

    typedef enum logic [2:0] {
        idle,
        header,
        header_last,
        payload,
        drain,
        discard
    } state_t;

    state_t     state, state_next;
    ip_hdr_t    ip_q;
    len_t       count, count_next;
    logic       hdr_word, hdr_word_next;
    logic       hdr_ready_next, eth_valid_next, err_next;
    logic       payload_en, hdr_accept, done;
    axis_word_t build;
    logic [3:0] lead, avail;
    logic       fits;

    // word 2 carries the destination address in its low half
    always_comb begin
        build = shift_word;
        lead = 4'd0;
        if (state == header_last) begin
            build.data = {shift_word.data[63:32], ip_q.dest_ip[7:0], ip_q.dest_ip[15:8],
                          ip_q.dest_ip[23:16], ip_q.dest_ip[31:24]};
            build.keep = {shift_word.keep[7:4], 4'hf};
            lead = 4'd4;
        end
        avail = keep_count(build.keep) - lead;
        fits = len_t'(avail) >= count;
    end

    always_comb begin
        state_next = state;
        hdr_word_next = hdr_word;
        count_next = count;
        hdr_ready_next = 1'b0;
        eth_valid_next = eth_valid && !eth_ready;
        err_next = 1'b0;
        hdr_accept = 1'b0;
        shift_take = 1'b0;
        frm_valid = 1'b0;
        frm_word = '0;
        done = 1'b0;

        case (state)
            idle: begin
                hdr_ready_next = 1'b1;
                if (hdr_valid && hdr_ready) begin
                    hdr_accept = 1'b1;
                    hdr_ready_next = 1'b0;
                    eth_valid_next = 1'b1;
                    hdr_word_next = 1'b0;
                    count_next = ip_hdr.length - len_t'(ip_hdr_bytes);
                    state_next = header;
                end
            end
            header: begin
                if (frm_ready) begin
                    frm_valid = 1'b1;
                    frm_word.keep = '1;
                    hdr_word_next = 1'b1;
                    if (hdr_word) begin
                        frm_word.data = {ip_q.src_ip[7:0], ip_q.src_ip[15:8],
                                         ip_q.src_ip[23:16], ip_q.src_ip[31:24],
                                         csum[7:0], csum[15:8], ip_q.protocol, ip_q.ttl};
                        state_next = header_last;
                    end else begin
                        frm_word.data = {ip_q.frag_offset[7:0], ip_q.flags,
                                         ip_q.frag_offset[12:8], ip_q.identification[7:0],
                                         ip_q.identification[15:8], ip_q.length[7:0],
                                         ip_q.length[15:8], ip_q.dscp, ip_q.ecn,
                                         ip_version_ihl};
                    end
                end
            end
            header_last, payload: begin
                if (payload_en && shift_valid) begin
                    shift_take = 1'b1;
                    frm_valid = 1'b1;
                    frm_word.data = build.data;
                    frm_word.keep = build.keep;
                    frm_word.last = build.last;
                    count_next = count - len_t'(avail);
                    if (fits) begin
                        // length reached, cut the word here
                        frm_word.keep = count_keep(count[3:0] + lead);
                        frm_word.last = 1'b1;
                        count_next = '0;
                        if (build.last) begin
                            done = 1'b1;
                        end else begin
                            state_next = discard;
                        end
                    end else if (build.last) begin
                        // input ended short of the declared length
                        frm_word.user = 1'b1;
                        err_next = 1'b1;
                        done = 1'b1;
                    end else begin
                        state_next = payload;
                    end
                end
            end
            discard: begin
                shift_take = shift_valid;
                if (shift_valid && shift_word.last) begin
                    done = 1'b1;
                end
            end
            drain: begin
                // wait for the ethernet header to leave
                if (!eth_valid_next) begin
                    hdr_ready_next = 1'b1;
                    state_next = idle;
                end
            end
            default: state_next = idle;
        endcase

        if (done) begin
            if (eth_valid_next) begin
                state_next = drain;
            end else begin
                hdr_ready_next = 1'b1;
                state_next = idle;
            end
        end
    end

    assign csum_load = hdr_accept;
    assign flush = done;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            hdr_word <= 1'b0;
            hdr_ready <= 1'b0;
            eth_valid <= 1'b0;
            payload_en <= 1'b0;
            error_early_term <= 1'b0;
        end else begin
            state <= state_next;
            hdr_word <= hdr_word_next;
            hdr_ready <= hdr_ready_next;
            eth_valid <= eth_valid_next;
            payload_en <= frm_ready_early
                && (state_next == header_last || state_next == payload);
            error_early_term <= err_next;
        end
        count <= count_next;
        if (hdr_accept) begin
            eth_out <= eth_hdr;
            ip_q <= ip_hdr;
        end
    end

    // the skid buffer has room for only the one word in flight
    assert property (@(posedge clk) disable iff (rst) frm_valid |-> frm_ready);

endmodule

//--- axis_skid_buffer.sv
// ==========================================================================
// registered output stage with a spare entry for the word in flight
// frm_ready is registered; frm_ready_early is its value for the next cycle
// ==========================================================================
module axis_skid_buffer
    import ip_tx_pkg::*;
#(
    parameter int data_bytes = 8
) (
    input  logic      clk,
    input  logic      rst,
    input  axis_out_t frm_word,
    input  logic      frm_valid,
    output logic      frm_ready,
    output logic      frm_ready_early,
    output axis_out_t out_word,
    output logic      out_valid,
    input  logic      out_ready
);

    if (data_bytes != bytes_per_word) begin : g_width_check
        $error("data_bytes does not match the package word size");
    end

    axis_out_t spare_word;
    logic      spare_valid, out_valid_next, spare_valid_next;
    logic      load_out, load_spare, spare_to_out;

    // open up when the output moves or both entries are empty
    assign frm_ready_early = out_ready || (!out_valid && !spare_valid);

    always_comb begin
        out_valid_next = out_valid;
        spare_valid_next = spare_valid;
        load_out = 1'b0;
        load_spare = 1'b0;
        spare_to_out = 1'b0;
        if (frm_ready) begin
            if (out_ready || !out_valid) begin
                out_valid_next = frm_valid;
                load_out = 1'b1;
            end else begin
                spare_valid_next = frm_valid;
                load_spare = 1'b1;
            end
        end else if (out_ready) begin
            out_valid_next = spare_valid;
            spare_valid_next = 1'b0;
            spare_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            spare_valid <= 1'b0;
            frm_ready <= 1'b0;
        end else begin
            out_valid <= out_valid_next;
            spare_valid <= spare_valid_next;
            frm_ready <= frm_ready_early;
        end
        if (load_out) begin
            out_word <= frm_word;
        end else if (spare_to_out) begin
            out_word <= spare_word;
        end
        if (load_spare) begin
            spare_word <= frm_word;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_word));

endmodule

//--- ip_eth_tx.sv
// ==========================================================================
// IPv4 transmitter top, 64-bit datapath, IHL fixed at 5
// payload output is registered; eth_out passes the Ethernet header through
// ==========================================================================
module ip_eth_tx
    import ip_tx_pkg::*;
#(
    parameter int data_bytes = 8
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       hdr_valid,
    output logic       hdr_ready,
    input  eth_hdr_t   eth_hdr,
    input  ip_hdr_t    ip_hdr,
    input  logic       in_valid,
    output logic       in_ready,
    input  axis_word_t in_word,
    output logic       eth_valid,
    input  logic       eth_ready,
    output eth_hdr_t   eth_out,
    output logic       out_valid,
    input  logic       out_ready,
    output axis_out_t  out_word,
    output logic       error_early_term
);

    axis_out_t  frm_word;
    logic       frm_valid, frm_ready, frm_ready_early;
    axis_word_t shift_word;
    logic       shift_valid, shift_take, flush;
    csum_t      csum;
    logic       csum_load;

    ip_tx_framer i_framer (
        .clk, .rst, .hdr_valid, .hdr_ready, .eth_hdr, .ip_hdr,
        .eth_valid, .eth_ready, .eth_out, .csum, .csum_load,
        .shift_word, .shift_valid, .shift_take, .flush,
        .frm_word, .frm_valid, .frm_ready, .frm_ready_early, .error_early_term
    );

    ip_hdr_checksum i_checksum (
        .clk, .rst, .load(csum_load), .ip_hdr, .csum
    );

    payload_realign #(.data_bytes(data_bytes)) i_realign (
        .clk, .rst, .in_word, .in_valid, .in_ready,
        .shift_word, .shift_valid, .shift_take, .flush
    );

    axis_skid_buffer #(.data_bytes(data_bytes)) i_skid (
        .clk, .rst, .frm_word, .frm_valid, .frm_ready, .frm_ready_early,
        .out_word, .out_valid, .out_ready
    );

endmodule

//--- tb_clk_gen.sv
// ==========================================================================
// testbench clock with period 10, rst held high for the first 2 rising edges
// ==========================================================================
module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // release 1 time unit after the edge, like the other inputs
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

//--- tb_checker.sv
// ==========================================================================
// rebuilds each expected frame from its header fields and payload pattern
// samples on the falling edge, where DUT outputs and tb inputs are stable
// frames must be registered with add_frame in output order
// ==========================================================================
module tb_checker
    import ip_tx_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      eth_valid,
    input  logic      eth_ready,
    input  eth_hdr_t  eth_out,
    input  logic      out_valid,
    input  logic      out_ready,
    input  axis_out_t out_word,
    input  logic      error_early_term,
    output int        errors,
    output int        frames_done
);

    string      name_q[$];
    ip_hdr_t    ip_q[$];
    eth_hdr_t   eth_q[$];
    logic [7:0] start_q[$];
    int         sent_q[$];

    // byte offset of the next output word within its frame
    int   pos = 0;
    int   eth_seen = 0;
    int   pulses = 0;
    int   pulse_frame = -1;
    logic err_prev = 1'b0;

    initial begin
        errors = 0;
        frames_done = 0;
    end

    task automatic add_frame(input string name, input ip_hdr_t h, input eth_hdr_t e,
                             input logic [7:0] start, input int sent);
        name_q.push_back(name);
        ip_q.push_back(h);
        eth_q.push_back(e);
        start_q.push_back(start);
        sent_q.push_back(sent);
    endtask

    // the 20 header bytes, byte 0 in the top bits, checksum filled in
    function automatic logic [159:0] header_bytes(ip_hdr_t h);
        logic [159:0] b;
        logic [19:0]  sum;
        b = {8'h45, h.dscp, h.ecn, h.length, h.identification, h.flags, h.frag_offset,
             h.ttl, h.protocol, 16'h0000, h.src_ip, h.dest_ip};
        sum = '0;
        for (int i = 0; i < 10; i++) begin
            sum = sum + 20'(b[159-16*i -: 16]);
        end
        sum = 20'(sum[15:0]) + 20'(sum[19:16]);
        sum = 20'(sum[15:0]) + 20'(sum[19:16]);
        b[79:64] = ~sum[15:0];
        return b;
    endfunction

    function automatic logic is_early(int f);
        return sent_q[f] < int'(ip_q[f].length) - 20;
    endfunction

    task automatic check_word();
        int           f;
        int           exp_len;
        int           n;
        logic [159:0] hdr;
        logic [7:0]   exp_b;
        logic [7:0]   act_b;
        keep_t        exp_keep;
        logic         exp_last;
        logic         exp_user;
        if (frames_done >= name_q.size()) begin
            $display("output word arrived after all expected frames were done");
            errors++;
            return;
        end
        f = frames_done;
        exp_len = is_early(f) ? 20 + sent_q[f] : int'(ip_q[f].length);
        n = exp_len - pos;
        if (n > 8) begin
            n = 8;
        end else if (n < 0) begin
            n = 0;
        end
        exp_keep = 8'hff >> (8 - n);
        exp_last = (pos + n == exp_len);
        exp_user = exp_last && is_early(f);
        hdr = header_bytes(ip_q[f]);
        for (int j = 0; j < n; j++) begin
            if (pos + j < 20) begin
                exp_b = hdr[159-8*(pos+j) -: 8];
            end else begin
                exp_b = 8'(int'(start_q[f]) + pos + j - 20);
            end
            act_b = out_word.data[8*j +: 8];
            if (act_b !== exp_b) begin
                $display("Error: %s byte %0d expected %02h actual %02h",
                         name_q[f], pos + j, exp_b, act_b);
                errors++;
            end
        end
        if (out_word.keep !== exp_keep || out_word.last !== exp_last
                || out_word.user !== exp_user) begin
            $display("Error: %s keep/last/user at byte %0d expected %02h/%0b/%0b actual %02h/%0b/%0b",
                     name_q[f], pos, exp_keep, exp_last, exp_user,
                     out_word.keep, out_word.last, out_word.user);
            errors++;
        end
        pos += 8;
        if (out_word.last) begin
            pos = 0;
            frames_done++;
        end
    endtask

    task automatic check_eth();
        if (eth_seen >= eth_q.size()) begin
            $display("ethernet header arrived after all expected frames were done");
            errors++;
        end else if (eth_out !== eth_q[eth_seen]) begin
            $display("Error: %s eth_out expected %h actual %h",
                     name_q[eth_seen], eth_q[eth_seen], eth_out);
            errors++;
        end
        eth_seen++;
    endtask

    // called once all frames are out
    task automatic check_counts();
        int early;
        early = 0;
        for (int f = 0; f < name_q.size(); f++) begin
            if (is_early(f)) begin
                early++;
            end
        end
        if (pulses != early) begin
            $display("Error: early_term_pulses expected %0d actual %0d", early, pulses);
            errors++;
        end
        if (eth_seen != name_q.size()) begin
            $display("Error: eth_header_count expected %0d actual %0d", name_q.size(), eth_seen);
            errors++;
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (error_early_term) begin
                pulses++;
                if (err_prev) begin
                    $display("error_early_term stayed high for more than one cycle");
                    errors++;
                end
                // the short frame's last word is counted only after its pulse
                if (frames_done >= name_q.size() || !is_early(frames_done)
                        || pulse_frame == frames_done) begin
                    $display("error_early_term pulsed outside a single short frame");
                    errors++;
                end
                pulse_frame = frames_done;
            end
            err_prev = error_early_term;
            if (eth_valid && eth_ready) begin
                check_eth();
            end
            if (out_valid && out_ready) begin
                check_word();
            end
        end
    end

endmodule

//--- tb_ip_eth_tx.sv
// ==========================================================================
// testbench top for the IPv4 transmitter, frames come from ip_eth_tx_stim.txt
// inputs change 1 time unit after the rising edge
// header and payload of one frame are driven together, frames one by one
// ==========================================================================
module tb_ip_eth_tx
    import ip_tx_pkg::*;
();

    logic       clk;
    logic       rst;
    logic       hdr_valid = 1'b0;
    logic       hdr_ready;
    eth_hdr_t   eth_hdr = '0;
    ip_hdr_t    ip_hdr = '0;
    logic       in_valid = 1'b0;
    logic       in_ready;
    axis_word_t in_word = '0;
    logic       eth_valid;
    logic       eth_ready = 1'b1;
    eth_hdr_t   eth_out;
    logic       out_valid;
    logic       out_ready = 1'b1;
    axis_out_t  out_word;
    logic       error_early_term;

    int         errors;
    int         frames_done;
    logic       bp_on = 1'b0;
    int         limit_cycles = 0;

    eth_hdr_t   eth_list[$];
    ip_hdr_t    ip_list[$];
    logic [7:0] start_list[$];
    int         sent_list[$];
    logic       bp_list[$];

    tb_clk_gen i_clk_gen (.clk, .rst);

    ip_eth_tx #(.data_bytes(8)) i_dut (
        .clk, .rst, .hdr_valid, .hdr_ready, .eth_hdr, .ip_hdr,
        .in_valid, .in_ready, .in_word, .eth_valid, .eth_ready, .eth_out,
        .out_valid, .out_ready, .out_word, .error_early_term
    );

    tb_checker i_checker (
        .clk, .rst, .eth_valid, .eth_ready, .eth_out, .out_valid, .out_ready,
        .out_word, .error_early_term, .errors, .frames_done
    );

    // handshakes are judged at the falling edge, the transfer is the next rise
    task automatic send_header(input eth_hdr_t e, input ip_hdr_t h);
        eth_hdr = e;
        ip_hdr = h;
        hdr_valid = 1'b1;
        do @(negedge clk); while (!hdr_ready);
        @(posedge clk);
        #1;
        hdr_valid = 1'b0;
    endtask

    task automatic send_payload(input logic [7:0] start, input int sent);
        int pos;
        int n;
        pos = 0;
        while (pos < sent) begin
            n = (sent - pos > 8) ? 8 : sent - pos;
            in_word.data = '0;
            for (int j = 0; j < n; j++) begin
                in_word.data[8*j +: 8] = 8'(int'(start) + pos + j);
            end
            in_word.keep = 8'hff >> (8 - n);
            in_word.last = (pos + n >= sent);
            in_valid = 1'b1;
            do @(negedge clk); while (!in_ready);
            @(posedge clk);
            #1;
            pos += n;
        end
        in_valid = 1'b0;
    endtask

    // random back-pressure on both outputs while the flag is set
    always @(posedge clk) begin
        #1;
        if (bp_on) begin
            out_ready = ($urandom % 3) != 0;
            eth_ready = ($urandom % 2) != 0;
        end else begin
            out_ready = 1'b1;
            eth_ready = 1'b1;
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("run timed out after %0d cycles with %0d frames done",
                 limit_cycles, frames_done);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        string       line;
        string       name;
        int          fd;
        int          r;
        int          words;
        logic [47:0] dmac;
        logic [47:0] smac;
        logic [15:0] etype;
        logic [15:0] id;
        logic [31:0] sip;
        logic [31:0] dip;
        logic [7:0]  start;
        int          dscp, ecn, len, flags, frag, ttl, proto, sent, bp;
        eth_hdr_t    e;
        ip_hdr_t     h;
        words = 0;
        r = $urandom(32'hb54d);
        fd = $fopen("ip_eth_tx_stim.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                r = $fgets(line, fd);
                if (line.len() > 1 && line.getc(0) != "#") begin
                    r = $sscanf(line, "%s %h %h %h %d %d %d %h %d %d %d %d %h %h %h %d %d",
                                name, dmac, smac, etype, dscp, ecn, len, id, flags, frag,
                                ttl, proto, sip, dip, start, sent, bp);
                    if (r == 17) begin
                        e = '{dest_mac: dmac, src_mac: smac, eth_type: etype};
                        h = '{dscp: 6'(dscp), ecn: 2'(ecn), length: 16'(len),
                              identification: id, flags: 3'(flags),
                              frag_offset: 13'(frag), ttl: 8'(ttl), protocol: 8'(proto),
                              src_ip: sip, dest_ip: dip};
                        eth_list.push_back(e);
                        ip_list.push_back(h);
                        start_list.push_back(start);
                        sent_list.push_back(sent);
                        bp_list.push_back(bp != 0);
                        i_checker.add_frame(name, h, e, start, sent);
                        words += (((len > sent + 20) ? len : sent + 20) + 7) / 8;
                    end
                end
            end
            $fclose(fd);
        end
        if (ip_list.size() == 0) begin
            $display("no frames could be read from ip_eth_tx_stim.txt");
            $display("Testbench failed");
            $finish;
        end
        limit_cycles = words * 20 + 1000;

        wait (!rst);
        @(posedge clk);
        #1;
        for (int i = 0; i < ip_list.size(); i++) begin
            bp_on = bp_list[i];
            fork
                send_header(eth_list[i], ip_list[i]);
                send_payload(start_list[i], sent_list[i]);
            join
        end
        wait (frames_done == ip_list.size());
        // leave room for a trailing error pulse
        repeat (4) @(posedge clk);
        i_checker.check_counts();
        @(posedge clk);
        $display("frames checked %0d of %0d, errors %0d", frames_done, ip_list.size(), errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- ip_eth_tx_stim.txt
# name dest_mac src_mac eth_type dscp ecn length id flags frag ttl proto src_ip dest_ip start sent bp
# hex: macs, eth_type, id, ips, start; decimal: dscp ecn length flags frag ttl proto sent bp
exact_two_words 0a1b2c3d4e5f 020000000001 0800 0 0 36 1234 2 0 64 17 c0a80001 c0a80002 00 16 0
short_three ffffffffffff 020000000002 0800 46 1 23 abcd 0 0 128 6 0a000001 0a0000fe 10 3 0
exact_four 001122334455 66778899aabb 0800 10 2 24 0001 1 100 32 1 ac100001 ac100002 f0 4 0
exact_five 001122334455 66778899aabb 0800 63 3 25 ffff 7 8191 255 255 ffffffff ffffffff fe 5 0
exact_thirteen 0a1b2c3d4e5f 020000000001 0800 8 0 33 7f00 2 0 64 17 c0a80001 c0a80002 20 13 0
trim_ten_of_24 0a1b2c3d4e5f 020000000003 0800 0 0 30 0042 2 0 64 17 c0a80101 c0a80102 30 24 0
trim_two_of_8 0a1b2c3d4e5f 020000000004 86dd 0 0 22 0043 0 0 1 6 01020304 05060708 40 8 0
trim_twelve_of_21 0a1b2c3d4e5f 020000000005 0800 12 1 32 0044 4 12 99 17 fffefdfc 80000001 50 21 0
early_17_of_30 0a1b2c3d4e5f 020000000006 0800 0 0 50 0045 2 0 64 17 c0a80001 c0a80002 60 17 0
early_2_of_40 0a1b2c3d4e5f 020000000007 0800 0 0 60 0046 2 0 64 6 c0a80001 c0a80002 70 2 0
early_6_of_40 0a1b2c3d4e5f 020000000008 0800 0 0 60 0047 2 0 64 6 c0a80001 c0a80002 80 6 0
long_plain 112233445566 aabbccddeeff 0800 34 0 100 5555 2 0 60 17 0a0a0a0a 0b0b0b0b 90 80 0
long_bp 112233445566 aabbccddeeff 0800 34 0 100 5555 2 0 60 17 0a0a0a0a 0b0b0b0b 90 80 1
trim_bp 112233445566 aabbccddeeff 0800 0 3 64 5556 1 77 61 17 0a0a0a0a 0b0b0b0b a0 70 1
early_bp 112233445566 aabbccddeeff 0800 5 0 120 5557 2 0 62 6 0a0a0a0a 0b0b0b0b b0 45 1
long_200_bp 112233445566 aabbccddeeff 0800 48 2 200 5558 3 4000 63 17 c0000201 c6336402 c0 180 1

//--- list.f
ip_tx_pkg.sv
ip_hdr_checksum.sv
payload_realign.sv
ip_tx_framer.sv
axis_skid_buffer.sv
ip_eth_tx.sv
tb_clk_gen.sv
tb_checker.sv
tb_ip_eth_tx.sv

//--- Bender.yml
package:
  name: ip_eth_tx

sources:
  - ip_tx_pkg.sv
  - ip_hdr_checksum.sv
  - payload_realign.sv
  - ip_tx_framer.sv
  - axis_skid_buffer.sv
  - ip_eth_tx.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_checker.sv
      - tb_ip_eth_tx.sv
